//--- logic/line_pkg.sv
package line_pkg;

    // Row memory depth and legal width range
    localparam int MAX_WIDTH = 256;
    localparam int MIN_WIDTH = 3;

    localparam int PIXEL_W = 8;

    typedef logic [PIXEL_W-1:0] pixel_t;

    // Column index, also carries the image width
    typedef logic [7:0] col_idx_t;

    // One vertical column of the window, top row first
    typedef struct packed {
        pixel_t top;
        pixel_t mid;
        pixel_t bot;
    } column_t;

    // One horizontal row of a window, leftmost pixel in the high byte
    typedef struct packed {
        pixel_t left;
        pixel_t centre;
        pixel_t right;
    } row3_t;

endpackage

//--- logic/store_ctrl_if.sv
`timescale 1ns/100ps

interface store_ctrl_if;

    // Store column at the current address, then advance
    logic write;
    // Address back to column zero
    logic rewind;
    // Top row stored as zero
    logic first_row;
    // Zero bottom pixel, memories untouched
    logic no_input;
    // Address sits on the last column of the image
    logic col_last;

    modport ctrl (
        output write,
        output rewind,
        output first_row,
        output no_input,
        input  col_last
    );

    modport store (
        input  write,
        input  rewind,
        input  first_row,
        input  no_input,
        output col_last
    );

endinterface

//--- logic/line_ctrl.sv
`timescale 1ns/100ps

module line_ctrl (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         start_first_row,
    input  logic         start_mid_row,
    input  logic         start_last_row,
    input  logic         s_axis_tvalid,
    output logic         s_axis_tready,
    output logic         idle,
    output logic         done_row,
    output logic         shift,
    output logic         pad,
    output logic         clear,
    store_ctrl_if.ctrl   st
);

    typedef enum logic [2:0] {
        reset_st,
        idle_st,
        first_stream_st,
        left_pad_st,
        mid_stream_st,
        last_stream_st,
        right_pad_st,
        finish_st
    } state_t;

    state_t state;
    state_t state_nxt;
    logic   last_mode;
    logic   accept;

    assign accept = s_axis_tvalid && s_axis_tready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= reset_st;
            last_mode <= 1'b0;
        end else begin
            state <= state_nxt;
            // Remember which row type follows the shared left pad
            if (state == idle_st) begin
                last_mode <= start_last_row;
            end
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            reset_st: begin
                state_nxt = idle_st;
            end
            idle_st: begin
                if (start_first_row) begin
                    state_nxt = first_stream_st;
                end else if (start_mid_row || start_last_row) begin
                    state_nxt = left_pad_st;
                end
            end
            first_stream_st: begin
                if (accept && st.col_last) begin
                    state_nxt = finish_st;
                end
            end
            left_pad_st: begin
                state_nxt = last_mode ? last_stream_st : mid_stream_st;
            end
            mid_stream_st: begin
                if (accept && st.col_last) begin
                    state_nxt = right_pad_st;
                end
            end
            last_stream_st: begin
                // One stored column per cycle, no input needed
                if (st.col_last) begin
                    state_nxt = right_pad_st;
                end
            end
            right_pad_st: begin
                state_nxt = finish_st;
            end
            finish_st: begin
                state_nxt = idle_st;
            end
            default: begin
                state_nxt = reset_st;
            end
        endcase
    end

    always_comb begin
        s_axis_tready = 1'b0;
        idle          = 1'b0;
        done_row      = 1'b0;
        shift         = 1'b0;
        pad           = 1'b0;
        clear         = 1'b0;
        st.write      = 1'b0;
        st.rewind     = 1'b0;
        st.first_row  = 1'b0;
        st.no_input   = 1'b0;
        case (state)
            idle_st: begin
                idle      = 1'b1;
                clear     = 1'b1;
                st.rewind = 1'b1;
            end
            first_stream_st: begin
                s_axis_tready = 1'b1;
                st.first_row  = 1'b1;
                st.write      = accept;
            end
            left_pad_st, right_pad_st: begin
                pad = 1'b1;
            end
            mid_stream_st: begin
                s_axis_tready = 1'b1;
                st.write      = accept;
                shift         = accept;
            end
            last_stream_st: begin
                st.no_input = 1'b1;
                st.write    = 1'b1;
                shift       = 1'b1;
            end
            finish_st: begin
                done_row = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

//--- logic/line_store.sv
`timescale 1ns/100ps

module line_store (
    input  logic               clk,
    input  logic               rst_n,
    input  line_pkg::col_idx_t image_width,
    input  line_pkg::pixel_t   pixel,
    store_ctrl_if.store        st,
    output line_pkg::column_t  column
);

    // Row A is the older stored row, row B the newer one
    line_pkg::pixel_t   row_a [line_pkg::MAX_WIDTH];
    line_pkg::pixel_t   row_b [line_pkg::MAX_WIDTH];

    line_pkg::col_idx_t addr;
    line_pkg::pixel_t   a_rd;
    line_pkg::pixel_t   b_rd;
    line_pkg::pixel_t   new_pix;

    // Asynchronous reads at the current column
    assign a_rd = row_a[addr];
    assign b_rd = row_b[addr];

    // Bottom padding for the last row
    assign new_pix = st.no_input ? '0 : pixel;

    assign column.top = a_rd;
    assign column.mid = b_rd;
    assign column.bot = new_pix;

    assign st.col_last = (addr == image_width - 8'd1);

    // B ages into A, new pixel lands in B
    always_ff @(posedge clk) begin
        if (st.write && !st.no_input) begin
            row_a[addr] <= st.first_row ? '0 : b_rd;
            row_b[addr] <= pixel;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            addr <= '0;
        end else if (st.rewind) begin
            addr <= '0;
        end else if (st.write) begin
            addr <= addr + 8'd1;
        end
    end

endmodule

//--- logic/window_shift.sv
`timescale 1ns/100ps

module window_shift (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              shift,
    input  logic              pad,
    input  logic              clear,
    input  line_pkg::column_t column,
    output logic              window_valid,
    output line_pkg::row3_t   win_top,
    output line_pkg::row3_t   win_mid,
    output line_pkg::row3_t   win_bot
);

    line_pkg::column_t col_l;
    line_pkg::column_t col_c;
    line_pkg::column_t col_r;
    line_pkg::column_t col_in;

    logic [1:0] fill;
    logic       step;

    assign step   = shift || pad;
    // Pad brings in an all-zero column
    assign col_in = pad ? '0 : column;

    // New columns enter on the right
    always_ff @(posedge clk) begin
        if (step) begin
            col_l <= col_c;
            col_c <= col_r;
            col_r <= col_in;
        end
    end

    // Stale columns stay masked until three fresh ones are in
    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            fill         <= 2'd0;
            window_valid <= 1'b0;
        end else begin
            window_valid <= step && (fill >= 2'd2);
            if (step && (fill != 2'd3)) begin
                fill <= fill + 2'd1;
            end
        end
    end

    assign win_top = {col_l.top, col_c.top, col_r.top};
    assign win_mid = {col_l.mid, col_c.mid, col_r.mid};
    assign win_bot = {col_l.bot, col_c.bot, col_r.bot};

endmodule

//--- logic/line_buffer_top.sv
`timescale 1ns/100ps

module line_buffer_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start_first_row,
    input  logic               start_mid_row,
    input  logic               start_last_row,
    input  line_pkg::col_idx_t image_width,
    input  logic               s_axis_tvalid,
    input  line_pkg::pixel_t   s_axis_tdata,
    output logic               s_axis_tready,
    output logic               idle,
    output logic               done_row,
    output logic               window_valid,
    output line_pkg::row3_t    win_top,
    output line_pkg::row3_t    win_mid,
    output line_pkg::row3_t    win_bot
);

    store_ctrl_if st_bus ();

    logic              shift;
    logic              pad;
    logic              clear;
    line_pkg::column_t column;

    line_ctrl u_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .start_first_row (start_first_row),
        .start_mid_row   (start_mid_row),
        .start_last_row  (start_last_row),
        .s_axis_tvalid   (s_axis_tvalid),
        .s_axis_tready   (s_axis_tready),
        .idle            (idle),
        .done_row        (done_row),
        .shift           (shift),
        .pad             (pad),
        .clear           (clear),
        .st              (st_bus.ctrl)
    );

    line_store u_store (
        .clk         (clk),
        .rst_n       (rst_n),
        .image_width (image_width),
        .pixel       (s_axis_tdata),
        .st          (st_bus.store),
        .column      (column)
    );

    window_shift u_shift (
        .clk          (clk),
        .rst_n        (rst_n),
        .shift        (shift),
        .pad          (pad),
        .clear        (clear),
        .column       (column),
        .window_valid (window_valid),
        .win_top      (win_top),
        .win_mid      (win_mid),
        .win_bot      (win_bot)
    );

endmodule

//--- test/tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
    parameter real PERIOD_NS = 20.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // Free running, half period per phase
    always begin
        #(PERIOD_NS / 2.0);
        clk = ~clk;
    end

endmodule

//--- test/line_buffer_asserts.sv
`timescale 1ns/100ps

module line_buffer_asserts (
    input logic               clk,
    input logic               rst_n,
    input logic               start_first_row,
    input logic               start_mid_row,
    input logic               start_last_row,
    input line_pkg::col_idx_t image_width,
    input logic               s_axis_tready,
    input logic               idle,
    input logic               done_row,
    input logic               window_valid
);

    // No pixel taken while waiting for a command
    ready_not_idle: assert property (@(posedge clk) disable iff (!rst_n)
        idle |-> !s_axis_tready)
        else $error("tready high while idle");

    done_single: assert property (@(posedge clk) disable iff (!rst_n)
        done_row |=> !done_row)
        else $error("done_row high two cycles in a row");

    window_not_idle: assert property (@(posedge clk) disable iff (!rst_n)
        idle |-> !window_valid)
        else $error("window_valid high while idle");

    width_legal: assert property (@(posedge clk) disable iff (!rst_n)
        (idle && (start_first_row || start_mid_row || start_last_row))
            |-> (image_width >= line_pkg::MIN_WIDTH))
        else $error("row started with an illegal width");

endmodule

//--- test/line_buffer_tb.sv
`timescale 1ns/100ps

module line_buffer_tb;

    typedef enum logic [1:0] {
        cmd_first,
        cmd_mid,
        cmd_last
    } row_cmd_t;

    typedef struct {
        row_cmd_t cmd;
        int       width;
        int       gap_pct;
    } row_entry_t;

    localparam int NUM_ROWS = 8;
    localparam int IDLE_TIMEOUT = 100;

    // Width 5 image of four rows, then width 3 image of two rows
    row_entry_t rows [NUM_ROWS] = '{
        '{cmd_first, 5, 0},
        '{cmd_mid,   5, 0},
        '{cmd_mid,   5, 40},
        '{cmd_mid,   5, 60},
        '{cmd_last,  5, 0},
        '{cmd_first, 3, 30},
        '{cmd_mid,   3, 50},
        '{cmd_last,  3, 0}
    };

    logic               clk;
    logic               rst_n;
    logic               start_first_row;
    logic               start_mid_row;
    logic               start_last_row;
    line_pkg::col_idx_t image_width;
    logic               s_axis_tvalid;
    line_pkg::pixel_t   s_axis_tdata;
    logic               s_axis_tready;
    logic               idle;
    logic               done_row;
    logic               window_valid;
    line_pkg::row3_t    win_top;
    line_pkg::row3_t    win_mid;
    line_pkg::row3_t    win_bot;

    // Reference rows, A older, B newer, C incoming
    line_pkg::pixel_t ref_a [line_pkg::MAX_WIDTH];
    line_pkg::pixel_t ref_b [line_pkg::MAX_WIDTH];
    line_pkg::pixel_t ref_c [line_pkg::MAX_WIDTH];
    line_pkg::row3_t  exp_top [line_pkg::MAX_WIDTH];
    line_pkg::row3_t  exp_mid [line_pkg::MAX_WIDTH];
    line_pkg::row3_t  exp_bot [line_pkg::MAX_WIDTH];

    tb_clock #(.PERIOD_NS(20.0)) u_clock (.clk(clk));

    line_buffer_top uut (.*);

    bind line_buffer_top line_buffer_asserts u_asserts (.*);

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_row3(input string name, input line_pkg::row3_t got,
                              input line_pkg::row3_t exp);
        if (got !== exp) begin
            stop_run($sformatf("MISMATCH time %0t %s got %h expected %h",
                               $time, name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input line_pkg::col_idx_t got,
                               input line_pkg::col_idx_t exp);
        if (got !== exp) begin
            stop_run($sformatf("MISMATCH time %0t %s got %0d expected %0d",
                               $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("MISMATCH time %0t %s got %b expected %b",
                               $time, name, got, exp));
        end
    endtask

    function automatic line_pkg::pixel_t padded(input line_pkg::pixel_t r [line_pkg::MAX_WIDTH],
                                                input int x, input int w);
        if (x < 0 || x >= w) begin
            return '0;
        end
        return r[x];
    endfunction

    // Window x takes columns x-1 to x+1 of A, B and C
    task automatic build_expected(input int w);
        for (int x = 0; x < w; x++) begin
            exp_top[x] = '{padded(ref_a, x - 1, w), padded(ref_a, x, w), padded(ref_a, x + 1, w)};
            exp_mid[x] = '{padded(ref_b, x - 1, w), padded(ref_b, x, w), padded(ref_b, x + 1, w)};
            exp_bot[x] = '{padded(ref_c, x - 1, w), padded(ref_c, x, w), padded(ref_c, x + 1, w)};
        end
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (idle !== 1'b1) begin
            @(posedge clk);
            cycles++;
            if (cycles > IDLE_TIMEOUT) begin
                stop_run("timeout waiting for idle");
            end
        end
    endtask

    task automatic run_row(input row_entry_t r);
        int  sent;
        int  got_win;
        int  cycles;
        int  limit;
        bit  done_seen;
        bit  accepted;
        sent      = 0;
        got_win   = 0;
        cycles    = 0;
        done_seen = 0;
        limit     = r.width * 30 + 50;
        for (int x = 0; x < r.width; x++) begin
            ref_c[x] = (r.cmd == cmd_last) ? '0 : line_pkg::pixel_t'($urandom);
        end
        if (r.cmd != cmd_first) begin
            build_expected(r.width);
        end
        wait_idle();
        @(posedge clk);
        image_width     <= line_pkg::col_idx_t'(r.width);
        start_first_row <= (r.cmd == cmd_first);
        start_mid_row   <= (r.cmd == cmd_mid);
        start_last_row  <= (r.cmd == cmd_last);
        @(posedge clk);
        start_first_row <= 1'b0;
        start_mid_row   <= 1'b0;
        start_last_row  <= 1'b0;
        while (!done_seen) begin
            @(posedge clk);
            cycles++;
            if (cycles > limit) begin
                stop_run("timeout waiting for done_row");
            end
            accepted = s_axis_tvalid && s_axis_tready;
            if (r.cmd == cmd_last) begin
                check_bit("s_axis_tready", s_axis_tready, 1'b0);
            end
            if (r.cmd == cmd_first) begin
                check_bit("window_valid", window_valid, 1'b0);
            end
            if (accepted) begin
                sent++;
            end
            if (window_valid) begin
                if (got_win >= r.width) begin
                    stop_run("more windows than columns in a row");
                end
                check_row3("win_top", win_top, exp_top[got_win]);
                check_row3("win_mid", win_mid, exp_mid[got_win]);
                check_row3("win_bot", win_bot, exp_bot[got_win]);
                got_win++;
            end
            done_seen = done_row;
            // Hold an offered pixel until taken
            if (r.cmd != cmd_last && sent < r.width) begin
                if (!(s_axis_tvalid && !accepted)) begin
                    s_axis_tvalid <= (($urandom % 100) >= r.gap_pct);
                    s_axis_tdata  <= ref_c[sent];
                end
            end else begin
                s_axis_tvalid <= 1'b0;
            end
        end
        check_count("windows", line_pkg::col_idx_t'(got_win),
                    line_pkg::col_idx_t'((r.cmd == cmd_first) ? 0 : r.width));
        check_count("pixels", line_pkg::col_idx_t'(sent),
                    line_pkg::col_idx_t'((r.cmd == cmd_last) ? 0 : r.width));
        @(posedge clk);
        check_bit("idle", idle, 1'b1);
        // Age the stored rows
        if (r.cmd != cmd_last) begin
            for (int x = 0; x < r.width; x++) begin
                ref_a[x] = (r.cmd == cmd_first) ? '0 : ref_b[x];
                ref_b[x] = ref_c[x];
            end
        end
    endtask

    initial begin
        void'($urandom(75076));
        rst_n           = 1'b0;
        start_first_row = 1'b0;
        start_mid_row   = 1'b0;
        start_last_row  = 1'b0;
        image_width     = 8'd5;
        s_axis_tvalid   = 1'b0;
        s_axis_tdata    = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        wait_idle();
        check_bit("s_axis_tready", s_axis_tready, 1'b0);
        check_bit("done_row", done_row, 1'b0);
        check_bit("window_valid", window_valid, 1'b0);
        foreach (rows[i]) begin
            run_row(rows[i]);
        end
        $display("sim passed");
        $finish;
    end

endmodule

//--- sim.f
logic/line_pkg.sv
logic/store_ctrl_if.sv
logic/line_ctrl.sv
logic/line_store.sv
logic/window_shift.sv
logic/line_buffer_top.sv
test/tb_clock.sv
test/line_buffer_asserts.sv
test/line_buffer_tb.sv

//--- Bender.yml
package:
  name: line_buffer

sources:
  - logic/line_pkg.sv
  - logic/store_ctrl_if.sv
  - logic/line_ctrl.sv
  - logic/line_store.sv
  - logic/window_shift.sv
  - logic/line_buffer_top.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/line_buffer_asserts.sv
      - test/line_buffer_tb.sv
